//--- common/mem_pkg.sv
// memory-side types shared by the readout, the arbiter and the clear engine
package mem_pkg;

   // one memory word carries four packed 8-bit pixels
   typedef logic [31:0] word_t;

   // word address into either memory bank
   typedef logic [18:0] addr_t;

   // pixels per word
   localparam int LANES = 4;

   // selects one pixel lane inside a word
   typedef logic [$clog2(LANES)-1:0] lane_t;

   // cycles from address to valid read data
   // the readout holds each address one cycle longer than this
   localparam int READ_LATENCY = 2;

endpackage

//--- common/frame_pkg.sv
// image-side types and the board frame geometry
package frame_pkg;

   // grayscale pixel as sent out of the readout
   typedef logic [7:0] pixel_t;

   // virtual camera offset and angle
   typedef logic [10:0] view_t;
   typedef logic [8:0] angle_t;

   // board geometry with 1024 pixels per row as 256 words
   localparam int ROW_WORDS_DEFAULT = 256;
   localparam int ROWS_DEFAULT = 768;
   // cycles per pixel slot, slow enough for a serial link
   localparam int PACE_DEFAULT = 16384;
   // whole bank of memory 1
   localparam int CLEAR_DEPTH_DEFAULT = 2 ** 19;

endpackage

//--- common/mem_port_if.sv
// one request port into a word-wide memory
// read data comes back READ_LATENCY cycles after the address
interface mem_port_if;

   mem_pkg::addr_t addr;
   logic we;
   mem_pkg::word_t wdata;
   mem_pkg::word_t rdata;

   // side that issues addresses
   modport requester (
      output addr,
      output we,
      output wdata,
      input  rdata
   );

   // side that owns the memory pins
   modport memory (
      input  addr,
      input  we,
      input  wdata,
      output rdata
   );

endinterface

//--- frame_dump/dump_sequencer.sv
// frame lock plus the address walk of the readout
// each word holds its address, strobes the read word and waits for the serializer
module dump_sequencer #(
   parameter int ROW_WORDS = frame_pkg::ROW_WORDS_DEFAULT,
   parameter int ROWS = frame_pkg::ROWS_DEFAULT
) (
   input  logic clk,
   input  logic rst_n,
   input  logic save,
   mem_port_if.requester mem,
   output logic word_strobe,
   output mem_pkg::word_t word,
   input  logic lanes_done,
   output logic frame_locked,
   output logic dump_done
);

   localparam int LAT_W = $clog2(mem_pkg::READ_LATENCY + 1);

   typedef enum logic [1:0] {
      st_idle,
      st_wait_read,
      st_send
   } state_t;

   state_t state;
   logic [LAT_W-1:0] lat_cnt;
   // column within the row, row index and the word address of the row start
   mem_pkg::addr_t col;
   mem_pkg::addr_t row;
   mem_pkg::addr_t row_base;
   logic last_col;
   logic last_row;

   ////////////////////
   // address and read data

   assign last_col = (col == mem_pkg::addr_t'(ROW_WORDS - 1));
   assign last_row = (row == mem_pkg::addr_t'(ROWS - 1));

   assign mem.addr = row_base + col;
   // read-only port
   assign mem.we = 1'b0;
   assign mem.wdata = '0;

   // data is valid in the last hold cycle
   assign word_strobe = (state == st_wait_read) &&
                        (lat_cnt == LAT_W'(mem_pkg::READ_LATENCY));
   assign word = mem.rdata;

   ////////////////////
   // control FSM

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
         frame_locked <= 1'b0;
         dump_done <= 1'b0;
         lat_cnt <= '0;
         col <= '0;
         row <= '0;
         row_base <= '0;
      end else begin
         case (state)
            st_idle: begin
               // lock is one-shot, held until reset
               if (save && !frame_locked) begin
                  frame_locked <= 1'b1;
                  lat_cnt <= '0;
                  state <= st_wait_read;
               end
            end
            st_wait_read: begin
               if (word_strobe) begin
                  state <= st_send;
               end else begin
                  lat_cnt <= lat_cnt + 1'b1;
               end
            end
            st_send: begin
               // next address goes out the cycle after lanes_done
               if (lanes_done) begin
                  lat_cnt <= '0;
                  if (!last_col) begin
                     col <= col + 1'b1;
                     state <= st_wait_read;
                  end else if (!last_row) begin
                     col <= '0;
                     row <= row + 1'b1;
                     row_base <= row_base + mem_pkg::addr_t'(ROW_WORDS);
                     state <= st_wait_read;
                  end else begin
                     // whole frame sent so park in idle
                     col <= '0;
                     dump_done <= 1'b1;
                     state <= st_idle;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

//--- frame_dump/lane_serializer.sv
// splits one word into four pixels and paces them out
// lane order is 0, 3, 2, 1 as the link expects it
module lane_serializer #(
   parameter int PACE = frame_pkg::PACE_DEFAULT
) (
   input  logic clk,
   input  logic rst_n,
   input  logic word_strobe,
   input  mem_pkg::word_t word,
   output frame_pkg::pixel_t pixel,
   output logic send,
   output logic lanes_done
);

   localparam int PIX_W = $bits(frame_pkg::pixel_t);
   localparam int PACE_W = $clog2(PACE + 1);

   mem_pkg::word_t word_q;
   logic busy;
   // slot counts 0..3 and lane_sel is the pixel lane of that slot
   mem_pkg::lane_t slot;
   mem_pkg::lane_t lane_sel;
   logic [PACE_W-1:0] pace_cnt;

   // two's complement of the slot gives 0, 3, 2, 1
   assign lane_sel = ~slot + mem_pkg::lane_t'(1);
   assign pixel = word_q[lane_sel * PIX_W +: PIX_W];

   // word being unpacked
   always_ff @(posedge clk) begin
      if (word_strobe) begin
         word_q <= word;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
         slot <= '0;
         pace_cnt <= '0;
         send <= 1'b0;
         lanes_done <= 1'b0;
      end else begin
         // strobes are single cycle
         send <= 1'b0;
         lanes_done <= 1'b0;
         if (word_strobe) begin
            busy <= 1'b1;
            slot <= '0;
            pace_cnt <= '0;
            send <= 1'b1;
         end else if (busy) begin
            if (pace_cnt == PACE_W'(PACE - 1)) begin
               pace_cnt <= '0;
               if (slot == mem_pkg::lane_t'(mem_pkg::LANES - 1)) begin
                  busy <= 1'b0;
                  lanes_done <= 1'b1;
               end else begin
                  slot <= slot + 1'b1;
                  send <= 1'b1;
               end
            end else begin
               pace_cnt <= pace_cnt + 1'b1;
            end
         end
      end
   end

endmodule

//--- hdl/view_blackout.sv
// clears memory 1 whenever the camera view moves
// zeros are written only while blank is high
module view_blackout #(
   parameter int CLEAR_DEPTH = frame_pkg::CLEAR_DEPTH_DEFAULT
) (
   input  logic clk,
   input  logic rst_n,
   input  frame_pkg::view_t view_x,
   input  frame_pkg::view_t view_y,
   input  frame_pkg::angle_t view_angle,
   input  logic blank,
   output mem_pkg::addr_t mem1_addr,
   output logic mem1_we,
   output mem_pkg::word_t mem1_wdata
);

   frame_pkg::view_t prev_x;
   frame_pkg::view_t prev_y;
   frame_pkg::angle_t prev_angle;
   logic view_change;
   logic active;
   mem_pkg::addr_t sweep_addr;

   // last cycle's view
   always_ff @(posedge clk) begin
      prev_x <= view_x;
      prev_y <= view_y;
      prev_angle <= view_angle;
   end

   assign view_change = (view_x != prev_x) || (view_y != prev_y) ||
                        (view_angle != prev_angle);

   ////////////////////
   // sweep counter

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active <= 1'b0;
         sweep_addr <= '0;
      end else if (view_change) begin
         // any move restarts from the bottom
         active <= 1'b1;
         sweep_addr <= '0;
      end else if (active && blank) begin
         if (sweep_addr == mem_pkg::addr_t'(CLEAR_DEPTH - 1)) begin
            active <= 1'b0;
         end else begin
            sweep_addr <= sweep_addr + 1'b1;
         end
      end
   end

   assign mem1_addr = sweep_addr;
   assign mem1_we = active && blank;
   assign mem1_wdata = '0;

endmodule

//--- hdl/mem_port_arbiter.sv
// memory 0 port mux
// readout owns the port while the frame is locked, the host otherwise
module mem_port_arbiter (
   mem_port_if.memory dump,
   input  logic frame_locked,
   input  mem_pkg::addr_t host_addr,
   input  logic host_we,
   input  mem_pkg::word_t host_wdata,
   output mem_pkg::addr_t mem0_addr,
   output logic mem0_we,
   output mem_pkg::word_t mem0_wdata,
   input  mem_pkg::word_t mem0_rdata
);

   assign mem0_addr = frame_locked ? dump.addr : host_addr;
   // the locked frame must never be overwritten
   assign mem0_we = frame_locked ? 1'b0 : host_we;
   assign mem0_wdata = frame_locked ? dump.wdata : host_wdata;

   // read data goes back to the readout in either case
   assign dump.rdata = mem0_rdata;

endmodule

//--- hdl/frame_capture_top.sv
// frame readout and view-change clear
// memory 0 is shared with a host, memory 1 is cleared on view moves
module frame_capture_top #(
   parameter int ROW_WORDS = frame_pkg::ROW_WORDS_DEFAULT,
   parameter int ROWS = frame_pkg::ROWS_DEFAULT,
   parameter int PACE = frame_pkg::PACE_DEFAULT,
   parameter int CLEAR_DEPTH = frame_pkg::CLEAR_DEPTH_DEFAULT
) (
   input  logic clk,
   input  logic rst_n,
   // readout control and pixel stream
   input  logic save,
   output logic frame_locked,
   output logic dump_done,
   output frame_pkg::pixel_t pixel,
   output logic send,
   // memory 0
   output mem_pkg::addr_t mem0_addr,
   output logic mem0_we,
   output mem_pkg::word_t mem0_wdata,
   input  mem_pkg::word_t mem0_rdata,
   // host side of memory 0
   input  mem_pkg::addr_t host_addr,
   input  logic host_we,
   input  mem_pkg::word_t host_wdata,
   // camera view and blanking
   input  frame_pkg::view_t view_x,
   input  frame_pkg::view_t view_y,
   input  frame_pkg::angle_t view_angle,
   input  logic blank,
   // memory 1
   output mem_pkg::addr_t mem1_addr,
   output logic mem1_we,
   output mem_pkg::word_t mem1_wdata
);

   logic word_strobe;
   mem_pkg::word_t word;
   logic lanes_done;

   mem_port_if i_dump_port ();

   ////////////////////
   // frame readout

   dump_sequencer #(
      .ROW_WORDS (ROW_WORDS),
      .ROWS      (ROWS)
   ) i_dump_sequencer (
      .clk          (clk),
      .rst_n        (rst_n),
      .save         (save),
      .mem          (i_dump_port.requester),
      .word_strobe  (word_strobe),
      .word         (word),
      .lanes_done   (lanes_done),
      .frame_locked (frame_locked),
      .dump_done    (dump_done)
   );

   lane_serializer #(
      .PACE (PACE)
   ) i_lane_serializer (
      .clk         (clk),
      .rst_n       (rst_n),
      .word_strobe (word_strobe),
      .word        (word),
      .pixel       (pixel),
      .send        (send),
      .lanes_done  (lanes_done)
   );

   mem_port_arbiter i_mem_port_arbiter (
      .dump         (i_dump_port.memory),
      .frame_locked (frame_locked),
      .host_addr    (host_addr),
      .host_we      (host_we),
      .host_wdata   (host_wdata),
      .mem0_addr    (mem0_addr),
      .mem0_we      (mem0_we),
      .mem0_wdata   (mem0_wdata),
      .mem0_rdata   (mem0_rdata)
   );

   ////////////////////
   // render memory clear

   view_blackout #(
      .CLEAR_DEPTH (CLEAR_DEPTH)
   ) i_view_blackout (
      .clk        (clk),
      .rst_n      (rst_n),
      .view_x     (view_x),
      .view_y     (view_y),
      .view_angle (view_angle),
      .blank      (blank),
      .mem1_addr  (mem1_addr),
      .mem1_we    (mem1_we),
      .mem1_wdata (mem1_wdata)
   );

endmodule

//--- dv/frame_capture_properties.sv
// strobe and port rules of the top level
module frame_capture_properties (
   input logic clk,
   input logic rst_n,
   input logic send,
   input logic frame_locked,
   input logic mem0_we,
   input logic mem1_we,
   input logic blank
);

   // send is a single-cycle strobe, slots are never back to back
   send_single: assert property (@(posedge clk) disable iff (!rst_n) send |=> !send)
      else $error("send high on two consecutive cycles");

   // locked frame is read only
   locked_no_write: assert property (@(posedge clk) disable iff (!rst_n)
      frame_locked |-> !mem0_we)
      else $error("memory 0 write while frame locked");

   // memory 1 writes only in blanking
   clear_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
      mem1_we |-> blank)
      else $error("memory 1 write outside blanking");

endmodule

bind frame_capture_top frame_capture_properties i_frame_capture_properties (
   .clk          (clk),
   .rst_n        (rst_n),
   .send         (send),
   .frame_locked (frame_locked),
   .mem0_we      (mem0_we),
   .mem1_we      (mem1_we),
   .blank        (blank)
);

//--- dv/frame_capture_tb.sv
// top-level testbench for the frame readout and the view-change clear
module frame_capture_tb;

   localparam int ROW_WORDS = 3;
   localparam int ROWS = 2;
   localparam int PACE = 5;
   localparam int CLEAR_DEPTH = 6;
   localparam int SEED = 90;
   localparam int CLK_PERIOD = 10;

   ////////////////////
   // derived test lengths

   localparam int WORDS = ROW_WORDS * ROWS;
   localparam int PIXELS = WORDS * mem_pkg::LANES;
   // address hold, four pixel slots, one cycle for lanes_done
   localparam int WORD_CYCLES = mem_pkg::READ_LATENCY + 1 + mem_pkg::LANES * PACE + 1;
   localparam int DUMP_CYCLES = WORDS * WORD_CYCLES;
   localparam int RANDOM_CYCLES = 4 * CLEAR_DEPTH;
   localparam int TEST_CYCLES = 8 + WORDS + WORD_CYCLES + DUMP_CYCLES +
                                2 * (CLEAR_DEPTH + 4) + RANDOM_CYCLES;
   localparam int WATCHDOG_TIME = 2 * TEST_CYCLES * CLK_PERIOD;

   logic clk;
   logic rst_n;
   logic save;
   logic frame_locked;
   logic dump_done;
   frame_pkg::pixel_t pixel;
   logic send;
   mem_pkg::addr_t mem0_addr;
   logic mem0_we;
   mem_pkg::word_t mem0_wdata;
   mem_pkg::word_t mem0_rdata = '0;
   mem_pkg::addr_t host_addr;
   logic host_we;
   mem_pkg::word_t host_wdata;
   frame_pkg::view_t view_x;
   frame_pkg::view_t view_y;
   frame_pkg::angle_t view_angle;
   logic blank;
   mem_pkg::addr_t mem1_addr;
   logic mem1_we;
   mem_pkg::word_t mem1_wdata;

   // memory 0 contents and the frame the host wrote
   mem_pkg::word_t mem_model [mem_pkg::addr_t];
   mem_pkg::word_t frame_ref [$];

   int pix_count = 0;
   int lock_cycles = 0;
   // clear engine model state
   logic exp_active = 1'b0;
   int exp_addr = 0;
   // sweeps and restarts seen on the memory 1 port
   int sweeps_done = 0;
   int restarts = 0;
   int last_wr_addr = -1;
   frame_pkg::view_t prev_x = '0;
   frame_pkg::view_t prev_y = '0;
   frame_pkg::angle_t prev_angle = '0;

   frame_capture_top #(
      .ROW_WORDS   (ROW_WORDS),
      .ROWS        (ROWS),
      .PACE        (PACE),
      .CLEAR_DEPTH (CLEAR_DEPTH)
   ) i_frame_capture_top (
      .clk          (clk),
      .rst_n        (rst_n),
      .save         (save),
      .frame_locked (frame_locked),
      .dump_done    (dump_done),
      .pixel        (pixel),
      .send         (send),
      .mem0_addr    (mem0_addr),
      .mem0_we      (mem0_we),
      .mem0_wdata   (mem0_wdata),
      .mem0_rdata   (mem0_rdata),
      .host_addr    (host_addr),
      .host_we      (host_we),
      .host_wdata   (host_wdata),
      .view_x       (view_x),
      .view_y       (view_y),
      .view_angle   (view_angle),
      .blank        (blank),
      .mem1_addr    (mem1_addr),
      .mem1_we      (mem1_we),
      .mem1_wdata   (mem1_wdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////
   // failure reporting and compares

   task automatic report_failure(string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         report_failure($sformatf("** Error at time %0t: %s = %b, expected %b",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_pixel(string name, frame_pkg::pixel_t got, frame_pkg::pixel_t exp);
      if (got !== exp) begin
         report_failure($sformatf("** Error at time %0t: %s = 0x%h, expected 0x%h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_addr(string name, mem_pkg::addr_t got, mem_pkg::addr_t exp);
      if (got !== exp) begin
         report_failure($sformatf("** Error at time %0t: %s = 0x%h, expected 0x%h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_word(string name, mem_pkg::word_t got, mem_pkg::word_t exp);
      if (got !== exp) begin
         report_failure($sformatf("** Error at time %0t: %s = 0x%h, expected 0x%h",
                                  $time, name, got, exp));
      end
   endtask

   ////////////////////
   // reference model of the pixel stream

   // link order of the lanes inside a word
   function automatic int lane_of(int slot);
      case (slot)
         0: return 0;
         1: return 3;
         2: return 2;
         default: return 1;
      endcase
   endfunction

   function automatic frame_pkg::pixel_t expected_pixel(int n);
      int w;
      int row;
      int col;
      mem_pkg::word_t data;
      w = n / mem_pkg::LANES;
      row = w / ROW_WORDS;
      col = w % ROW_WORDS;
      data = frame_ref[row * ROW_WORDS + col];
      return frame_pkg::pixel_t'(data >> (lane_of(n % mem_pkg::LANES) *
                                          $bits(frame_pkg::pixel_t)));
   endfunction

   ////////////////////
   // memory 0 model answering READ_LATENCY edges after the address

   initial begin
      mem_pkg::addr_t rd_addr;
      mem_pkg::addr_t addr_pipe [$];
      // power-up pattern carries the full address
      for (int a = 0; a < WORDS; a++) begin
         mem_model[mem_pkg::addr_t'(a)] = {13'h1ab5, mem_pkg::addr_t'(a)};
      end
      repeat (mem_pkg::READ_LATENCY - 1) addr_pipe.push_back('0);
      forever begin
         @(posedge clk);
         if (mem0_we === 1'b1) begin
            mem_model[mem0_addr] = mem0_wdata;
         end
         addr_pipe.push_back(mem0_addr);
         rd_addr = addr_pipe.pop_front();
         #1;
         if (mem_model.exists(rd_addr)) begin
            mem0_rdata = mem_model[rd_addr];
         end else begin
            mem0_rdata = '0;
         end
      end
   end

   ////////////////////
   // pixel stream compare where cycle 0 is the first locked cycle

   always @(negedge clk) begin
      int slot_off;
      logic exp_send;
      if (rst_n && frame_locked) begin
         slot_off = (lock_cycles % WORD_CYCLES) - (mem_pkg::READ_LATENCY + 1);
         exp_send = (lock_cycles < DUMP_CYCLES) && (slot_off >= 0) &&
                    (slot_off < mem_pkg::LANES * PACE) && (slot_off % PACE == 0);
         check_bit("send", send, exp_send);
         check_bit("dump_done", dump_done, lock_cycles >= DUMP_CYCLES);
         if (exp_send) begin
            check_pixel("pixel", pixel, expected_pixel(
               (lock_cycles / WORD_CYCLES) * mem_pkg::LANES + slot_off / PACE));
         end
         if (send === 1'b1) begin
            pix_count++;
         end
         lock_cycles++;
      end else if (rst_n) begin
         check_bit("send", send, 1'b0);
         check_bit("dump_done", dump_done, 1'b0);
      end
   end

   ////////////////////
   // memory 1 clear model whose sweep starts the cycle after a view change

   always @(negedge clk) begin
      logic change;
      change = (view_x !== prev_x) || (view_y !== prev_y) || (view_angle !== prev_angle);
      if (!rst_n) begin
         exp_active = 1'b0;
         exp_addr = 0;
      end else begin
         check_bit("mem1_we", mem1_we, exp_active && blank);
         if (exp_active && blank) begin
            check_addr("mem1_addr", mem1_addr, mem_pkg::addr_t'(exp_addr));
            check_word("mem1_wdata", mem1_wdata, '0);
         end
         // a write at address 0 after a partial sweep is a restart
         if (mem1_we === 1'b1) begin
            if (mem1_addr == '0 && last_wr_addr > 0) begin
               restarts++;
            end
            if (mem1_addr == mem_pkg::addr_t'(CLEAR_DEPTH - 1)) begin
               sweeps_done++;
               last_wr_addr = -1;
            end else begin
               last_wr_addr = int'(mem1_addr);
            end
         end
         if (change) begin
            exp_active = 1'b1;
            exp_addr = 0;
         end else if (exp_active && blank) begin
            if (exp_addr == CLEAR_DEPTH - 1) begin
               exp_active = 1'b0;
            end else begin
               exp_addr++;
            end
         end
      end
      prev_x = view_x;
      prev_y = view_y;
      prev_angle = view_angle;
   end

   ////////////////////
   // stimulus

   task automatic step_cycle();
      @(posedge clk);
      #1;
   endtask

   // one host request and whether it reaches memory 0
   task automatic host_write(mem_pkg::addr_t a, mem_pkg::word_t d, logic exp_we);
      host_addr = a;
      host_wdata = d;
      host_we = 1'b1;
      @(negedge clk);
      check_bit("mem0_we", mem0_we, exp_we);
      if (exp_we) begin
         check_addr("mem0_addr", mem0_addr, a);
         check_word("mem0_wdata", mem0_wdata, d);
      end
      step_cycle();
      host_we = 1'b0;
   endtask

   initial begin
      mem_pkg::word_t data;
      void'($urandom(SEED));
      rst_n = 1'b0;
      save = 1'b0;
      host_addr = '0;
      host_we = 1'b0;
      host_wdata = '0;
      view_x = '0;
      view_y = '0;
      view_angle = '0;
      blank = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // outputs idle after reset
      @(negedge clk);
      check_bit("send", send, 1'b0);
      check_bit("frame_locked", frame_locked, 1'b0);
      check_bit("dump_done", dump_done, 1'b0);
      check_bit("mem1_we", mem1_we, 1'b0);
      check_bit("mem0_we", mem0_we, 1'b0);
      step_cycle();

      // host fills the frame through memory 0
      for (int a = 0; a < WORDS; a++) begin
         data = $urandom();
         frame_ref.push_back(data);
         host_write(mem_pkg::addr_t'(a), data, 1'b1);
      end
      for (int a = 0; a < WORDS; a++) begin
         check_word("mem_model", mem_model[mem_pkg::addr_t'(a)], frame_ref[a]);
      end

      // lock, then try to overwrite the last word mid-dump
      save = 1'b1;
      step_cycle();
      save = 1'b0;
      check_bit("frame_locked", frame_locked, 1'b1);
      repeat (WORD_CYCLES) step_cycle();
      host_write(mem_pkg::addr_t'(WORDS - 1), ~frame_ref[WORDS - 1], 1'b0);
      while (dump_done !== 1'b1) step_cycle();
      repeat (4) step_cycle();
      if (pix_count != PIXELS) begin
         report_failure($sformatf("dump ended after %0d pixel sends instead of %0d",
                                  pix_count, PIXELS));
      end
      for (int a = 0; a < WORDS; a++) begin
         check_word("mem_model", mem_model[mem_pkg::addr_t'(a)], frame_ref[a]);
      end

      // full sweep with blank held high
      blank = 1'b1;
      view_x = view_x + 1'b1;
      repeat (CLEAR_DEPTH + 4) step_cycle();
      if (sweeps_done != 1) begin
         report_failure("memory 1 clear did not finish with blank held high");
      end

      // random blank while a second move restarts the sweep
      // blank stays high up to the move so the sweep is past address 0
      view_y = view_y + 1'b1;
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         blank = (i <= 2) || (($urandom() % 2) == 1);
         if (i == 2) begin
            view_angle = view_angle + 1'b1;
         end
         step_cycle();
      end
      blank = 1'b1;
      repeat (CLEAR_DEPTH + 4) step_cycle();
      if (sweeps_done != 2 || restarts != 1) begin
         report_failure($sformatf("clear engine saw %0d sweeps and %0d restarts",
                                  sweeps_done, restarts));
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

   // bounds the whole run
   initial begin
      #(WATCHDOG_TIME);
      report_failure($sformatf("watchdog expired after %0d time units", WATCHDOG_TIME));
   end

endmodule

//--- frame_capture.f
common/mem_pkg.sv
common/frame_pkg.sv
common/mem_port_if.sv
frame_dump/dump_sequencer.sv
frame_dump/lane_serializer.sv
hdl/view_blackout.sv
hdl/mem_port_arbiter.sv
hdl/frame_capture_top.sv
dv/frame_capture_properties.sv
dv/frame_capture_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the frame capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module frame_capture_tb -f frame_capture.f

output=$(./obj_dir/Vframe_capture_tb 2>&1) || true
echo "$output"

if grep -q "STATUS: PASS" <<< "$output"; then
   exit 0
else
   exit 1
fi
